// File: csr_demux.f
+incdir+verilog
verilog/csr_demux_pkg.sv
verilog/csr_demux_if.sv
verilog/csr_req_decode.sv
verilog/csr_req_route.sv
verilog/csr_resp_merge.sv
verilog/csr_demux.sv
tb/csr_demux_assertions.sv
tb/csr_demux_tb.sv

// File: tb/csr_demux_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the CSR demux. Target models answer after
// 1, 3 and 5 cycles, windows at 0x0000, 0x1000 and 0x4000
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_demux_tb;

  localparam int N = `CSR_NUM_DOWNSTREAMS;
  localparam int S = `CSR_RETIME_STAGES;
  // Reset, 53 requests at their longest, the abort wait, then margin
  localparam int TIMEOUT_CYCLES = 10 + 53 * (3 + S + 5) + 12 + 100;

  logic                                                 clk = 1'b0;
  logic                                                 rst;
  logic                                                 upstream_req_valid;
  logic                                                 upstream_req_write;
  logic [`CSR_ADDR_WIDTH-1:0]                           upstream_req_addr;
  logic [`CSR_DATA_WIDTH-1:0]                           upstream_req_wdata;
  logic [`CSR_STRB_WIDTH-1:0]                           upstream_req_wstrb;
  logic                                                 upstream_req_privileged;
  logic                                                 upstream_req_secure;
  logic                                                 upstream_req_abort;
  logic                                                 upstream_resp_valid;
  logic [`CSR_DATA_WIDTH-1:0]                           upstream_resp_rdata;
  logic                                                 upstream_resp_decerr;
  logic                                                 upstream_resp_slverr;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_base;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_limit;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_valid;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_write;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_req_addr;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_DATA_WIDTH-1:0] downstream_req_wdata;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_STRB_WIDTH-1:0] downstream_req_wstrb;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_privileged;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_secure;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_abort;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_valid;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_DATA_WIDTH-1:0] downstream_resp_rdata;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_decerr;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_slverr;

  logic [N-1:0] model_pend;
  int           model_cnt [N];
  integer       seed = 32'h808dec9b;
  int           errors = 0;
  int           cycles = 0;

  csr_demux i_dut (.*);

  always #4 clk = ~clk;

  function automatic int target_delay(input int t);
    return 1 + 2 * t;
  endfunction

  function automatic logic [31:0] target_key(input int t);
    return 32'hC35A_0000 ^ (32'h0101_1111 * (t + 1));
  endfunction

  // Expected target from the fixed windows or -1 for a miss
  function automatic int window_of(input logic [15:0] addr);
    if (addr <= 16'h0FFF) return 0;
    if ((addr >= 16'h1000) && (addr <= 16'h1FFF)) return 1;
    if ((addr >= 16'h4000) && (addr <= 16'h40FF)) return 2;
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "check mismatch");
    end
  endtask

  // Target models sample and drive just after each rising edge
  always @(posedge clk) begin
    #1;
    for (int t = 0; t < N; t++) begin
      downstream_resp_valid[t] = 1'b0;
      if (rst || downstream_req_abort[t]) begin
        model_pend[t] = 1'b0;
      end else if (model_pend[t]) begin
        model_cnt[t] = model_cnt[t] - 1;
        if (model_cnt[t] == 0) begin
          model_pend[t]            = 1'b0;
          downstream_resp_valid[t] = 1'b1;
        end
      end
      if (!rst && (downstream_req_valid[t] === 1'b1)) begin
        model_pend[t] = 1'b1;
        model_cnt[t]  = target_delay(t);
        downstream_resp_rdata[t] = downstream_req_write[t] ? 32'h0 :
                                   ({16'h0, downstream_req_addr[t]} ^ target_key(t));
        downstream_resp_slverr[t] = !downstream_req_privileged[t];
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Any bound assertion failure ends the run
  always @(posedge clk) begin
    if (i_dut.i_assertions.failures != 0) begin
      $display("A bound protocol assertion failed");
      $display("TESTS FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // One request with the exact cycle of every expected response
  task automatic run_request(input logic [15:0] addr, input logic write,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             input logic priv, input logic secure);
    int          tgt;
    int          last;
    logic [31:0] exp_rdata;
    tgt       = window_of(addr);
    last      = (tgt < 0) ? 2 : 2 + S + target_delay(tgt);
    exp_rdata = ((tgt < 0) || write) ? 32'h0 : ({16'h0, addr} ^ target_key(tgt));
    upstream_req_valid      = 1'b1;
    upstream_req_write      = write;
    upstream_req_addr       = addr;
    upstream_req_wdata      = wdata;
    upstream_req_wstrb      = wstrb;
    upstream_req_privileged = priv;
    upstream_req_secure     = secure;
    for (int c = 1; c <= last; c++) begin
      @(posedge clk);
      #1;
      upstream_req_valid = 1'b0;
      check_value("downstream_req_valid", downstream_req_valid,
                  ((tgt >= 0) && (c == 1 + S)) ? (1 << tgt) : 0);
      if ((tgt >= 0) && (c == 1 + S)) begin
        check_value("downstream_req_write", downstream_req_write[tgt], write);
        check_value("downstream_req_addr", downstream_req_addr[tgt], addr);
        check_value("downstream_req_wdata", downstream_req_wdata[tgt], wdata);
        check_value("downstream_req_wstrb", downstream_req_wstrb[tgt], wstrb);
        check_value("downstream_req_privileged", downstream_req_privileged[tgt], priv);
        check_value("downstream_req_secure", downstream_req_secure[tgt], secure);
      end
      check_value("upstream_resp_valid", upstream_resp_valid, c == last);
    end
    check_value("upstream_resp_rdata", upstream_resp_rdata, exp_rdata);
    check_value("upstream_resp_decerr", upstream_resp_decerr, tgt < 0);
    check_value("upstream_resp_slverr", upstream_resp_slverr, (tgt >= 0) && !priv);
  endtask

  task automatic route_writes();
    run_request(16'h0123, 1'b1, $random(seed), 4'hF, 1'b1, 1'b0);
    run_request(16'h1ABC, 1'b1, $random(seed), 4'h3, 1'b1, 1'b1);
    run_request(16'h40F0, 1'b1, $random(seed), 4'hC, 1'b1, 1'b1);
  endtask

  task automatic return_reads();
    run_request(16'h0FFF, 1'b0, 32'h0, 4'h0, 1'b1, 1'b0);
    run_request(16'h1000, 1'b0, 32'h0, 4'h0, 1'b1, 1'b1);
    run_request(16'h4000, 1'b0, 32'h0, 4'h0, 1'b1, 1'b0);
  endtask

  // Unprivileged access gets slverr from the target
  task automatic pass_slave_error();
    run_request(16'h1234, 1'b0, 32'h0, 4'h0, 1'b0, 1'b0);
  endtask

  task automatic decode_misses();
    run_request(16'h2000, 1'b0, 32'h0, 4'h0, 1'b1, 1'b0);
    run_request(16'h4100, 1'b1, 32'h1, 4'hF, 1'b1, 1'b0);
    run_request(16'h3000, 1'b0, 32'h0, 4'h0, 1'b1, 1'b0);
    run_request(16'hFFFF, 1'b1, 32'h2, 4'h1, 1'b0, 1'b1);
  endtask

  // Abort one cycle after a read to the slowest target
  task automatic abort_in_flight();
    upstream_req_valid      = 1'b1;
    upstream_req_write      = 1'b0;
    upstream_req_addr       = 16'h4020;
    upstream_req_privileged = 1'b1;
    @(posedge clk);
    #1;
    upstream_req_valid = 1'b0;
    upstream_req_abort = 1'b1;
    for (int c = 1; c <= 12; c++) begin
      @(posedge clk);
      #1;
      upstream_req_abort = 1'b0;
      check_value("downstream_req_abort", downstream_req_abort, (c == 1 + S) ? 3'b111 : 3'b000);
      check_value("upstream_resp_valid", upstream_resp_valid, 1'b0);
    end
    run_request(16'h4004, 1'b0, 32'h0, 4'h0, 1'b1, 1'b0);
  endtask

  task automatic random_requests();
    logic [31:0] r;
    logic [15:0] addr;
    for (int n = 0; n < 40; n++) begin
      r    = $random(seed);
      addr = r[31:16];
      // Bias toward the windows so most requests hit
      if (r[0]) begin
        addr[15:13] = 3'b000;
      end else if (r[1]) begin
        addr[15:8] = 8'h40;
      end
      run_request(addr, r[2], $random(seed), r[7:4], r[3], r[8]);
    end
  endtask

  initial begin
    rst                     = 1'b1;
    upstream_req_valid      = 1'b0;
    upstream_req_write      = 1'b0;
    upstream_req_addr       = '0;
    upstream_req_wdata      = '0;
    upstream_req_wstrb      = '0;
    upstream_req_privileged = 1'b0;
    upstream_req_secure     = 1'b0;
    upstream_req_abort      = 1'b0;
    downstream_addr_base    = {16'h4000, 16'h1000, 16'h0000};
    downstream_addr_limit   = {16'h40FF, 16'h1FFF, 16'h0FFF};
    downstream_resp_valid   = '0;
    downstream_resp_rdata   = '0;
    downstream_resp_decerr  = '0;
    downstream_resp_slverr  = '0;
    model_pend              = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    route_writes();
    return_reads();
    pass_slave_error();
    decode_misses();
    abort_in_flight();
    random_requests();
    if ((errors == 0) && (i_dut.i_assertions.failures == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/csr_demux_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks bound into csr_demux. Assumes one upstream request
// outstanding and windows held static after reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_demux_assertions (
  input logic                                                 clk,
  input logic                                                 rst,
  input logic                                                 upstream_req_valid,
  input logic                                                 upstream_req_abort,
  input logic [`CSR_ADDR_WIDTH-1:0]                           upstream_req_addr,
  input logic                                                 upstream_resp_valid,
  input logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_base,
  input logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_limit,
  input logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_valid,
  input logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_abort,
  input logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_valid
);

  localparam int N = `CSR_NUM_DOWNSTREAMS;

  logic [N-1:0] ds_pend;
  logic         up_pend;
  logic         up_hit;
  // Count of failed assertions for the testbench verdict
  int           failures = 0;

  always_comb begin
    up_hit = 1'b0;
    for (int i = 0; i < N; i++) begin
      if ((upstream_req_addr >= downstream_addr_base[i]) &&
          (upstream_req_addr <= downstream_addr_limit[i])) begin
        up_hit = 1'b1;
      end
    end
  end

  // Outstanding requests where a new request wins over a completion
  always_ff @(posedge clk) begin
    if (rst) begin
      ds_pend <= '0;
      up_pend <= 1'b0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (downstream_req_valid[i]) begin
          ds_pend[i] <= 1'b1;
        end else if (downstream_resp_valid[i] || downstream_req_abort[i]) begin
          ds_pend[i] <= 1'b0;
        end
      end
      if (upstream_req_valid) begin
        up_pend <= 1'b1;
      end else if (upstream_resp_valid || upstream_req_abort) begin
        up_pend <= 1'b0;
      end
    end
  end

  a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(downstream_req_valid))
    else begin
      $error("downstream request valids not one-hot");
      failures = failures + 1;
    end

  a_up_resp: assert property (@(posedge clk) disable iff (rst) upstream_resp_valid |-> up_pend)
    else begin
      $error("upstream response without a pending request");
      failures = failures + 1;
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    (upstream_req_valid && up_hit) |-> ##(1 + `CSR_RETIME_STAGES) |downstream_req_valid)
    else begin
      $error("hitting request not forwarded on time");
      failures = failures + 1;
    end

  for (genvar g = 0; g < N; g++) begin : gen_ds
    a_ds_resp: assert property (@(posedge clk) disable iff (rst)
      downstream_resp_valid[g] |-> ds_pend[g])
      else begin
        $error("downstream %0d responded with nothing pending", g);
        failures = failures + 1;
      end
    a_window: assert property (@(posedge clk) disable iff (rst)
      downstream_addr_base[g] <= downstream_addr_limit[g])
      else begin
        $error("window %0d is inverted", g);
        failures = failures + 1;
      end
    for (genvar h = g + 1; h < N; h++) begin : gen_pair
      a_overlap: assert property (@(posedge clk) disable iff (rst)
        (downstream_addr_limit[g] < downstream_addr_base[h]) ||
        (downstream_addr_limit[h] < downstream_addr_base[g]))
        else begin
          $error("windows %0d and %0d overlap", g, h);
          failures = failures + 1;
        end
    end
  end

endmodule

bind csr_demux csr_demux_assertions i_assertions (.*);

`default_nettype wire

// File: verilog/csr_demux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR request demux top. One upstream request outstanding at a time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_demux (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 upstream_req_valid,
  input  logic                                                 upstream_req_write,
  input  logic [`CSR_ADDR_WIDTH-1:0]                           upstream_req_addr,
  input  logic [`CSR_DATA_WIDTH-1:0]                           upstream_req_wdata,
  input  logic [`CSR_STRB_WIDTH-1:0]                           upstream_req_wstrb,
  input  logic                                                 upstream_req_privileged,
  input  logic                                                 upstream_req_secure,
  input  logic                                                 upstream_req_abort,
  output logic                                                 upstream_resp_valid,
  output logic [`CSR_DATA_WIDTH-1:0]                           upstream_resp_rdata,
  output logic                                                 upstream_resp_decerr,
  output logic                                                 upstream_resp_slverr,
  // Inclusive window per downstream, held static
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_base,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_addr_limit,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_valid,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_write,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] downstream_req_addr,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_DATA_WIDTH-1:0] downstream_req_wdata,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_STRB_WIDTH-1:0] downstream_req_wstrb,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_privileged,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_secure,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_req_abort,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_valid,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_DATA_WIDTH-1:0] downstream_resp_rdata,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_decerr,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      downstream_resp_slverr
);

  csr_demux_pkg::csr_req_t  up_req;
  csr_demux_pkg::csr_resp_t up_resp;
  csr_demux_pkg::csr_req_t  ds_req [`CSR_NUM_DOWNSTREAMS];

  csr_req_if  u_dec_if ();
  csr_resp_if u_resp_if ();

  assign up_req.write      = upstream_req_write;
  assign up_req.privileged = upstream_req_privileged;
  assign up_req.secure     = upstream_req_secure;
  assign up_req.addr       = upstream_req_addr;
  assign up_req.wdata      = upstream_req_wdata;
  assign up_req.wstrb      = upstream_req_wstrb;

  assign u_resp_if.valid  = downstream_resp_valid;
  assign u_resp_if.rdata  = downstream_resp_rdata;
  assign u_resp_if.decerr = downstream_resp_decerr;
  assign u_resp_if.slverr = downstream_resp_slverr;

  csr_req_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (upstream_req_valid),
    .req_abort  (upstream_req_abort),
    .req        (up_req),
    .addr_base  (downstream_addr_base),
    .addr_limit (downstream_addr_limit),
    .dec        (u_dec_if.source)
  );

  csr_req_route u_route (
    .clk          (clk),
    .rst          (rst),
    .dec          (u_dec_if.sink),
    .ds_req_valid (downstream_req_valid),
    .ds_req_abort (downstream_req_abort),
    .ds_req       (ds_req)
  );

  csr_resp_merge u_merge (
    .clk        (clk),
    .rst        (rst),
    .dec        (u_dec_if.monitor),
    .ds         (u_resp_if.sink),
    .resp_valid (upstream_resp_valid),
    .resp       (up_resp)
  );

  // Unpack the shared payload onto the per-downstream ports
  for (genvar i = 0; i < `CSR_NUM_DOWNSTREAMS; i++) begin : gen_ds
    assign downstream_req_write[i]      = ds_req[i].write;
    assign downstream_req_privileged[i] = ds_req[i].privileged;
    assign downstream_req_secure[i]     = ds_req[i].secure;
    assign downstream_req_addr[i]       = ds_req[i].addr;
    assign downstream_req_wdata[i]      = ds_req[i].wdata;
    assign downstream_req_wstrb[i]      = ds_req[i].wstrb;
  end

  assign upstream_resp_rdata  = up_resp.rdata;
  assign upstream_resp_decerr = up_resp.decerr;
  assign upstream_resp_slverr = up_resp.slverr;

endmodule

`default_nettype wire

// File: verilog/csr_resp_merge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response merge. Assumes at most one candidate per cycle and gives
// the lowest downstream priority, the local miss last
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_resp_merge (
  input  logic                     clk,
  input  logic                     rst,
  csr_req_if.monitor               dec,
  csr_resp_if.sink                 ds,
  output logic                     resp_valid,
  output csr_demux_pkg::csr_resp_t resp
);

  localparam int N = `CSR_NUM_DOWNSTREAMS;

  logic                     miss;
  logic [N:0]               cand;
  csr_demux_pkg::csr_resp_t sel_resp;

  // Decoded request that matched no window
  assign miss = dec.valid && !dec.hit;
  assign cand = {miss, ds.valid};

  always_comb begin
    sel_resp = '0;
    for (int i = N; i >= 0; i--) begin
      if (cand[i]) begin
        if (i == N) begin
          // Local decode error response
          sel_resp.rdata  = '0;
          sel_resp.decerr = 1'b1;
          sel_resp.slverr = 1'b0;
        end else begin
          sel_resp.rdata  = ds.rdata[i];
          sel_resp.decerr = ds.decerr[i];
          sel_resp.slverr = ds.slverr[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= |cand;
    end
  end

  always_ff @(posedge clk) begin
    resp <= sel_resp;
  end

endmodule

`default_nettype wire

// File: verilog/csr_req_route.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Retime and fan out of decoded requests. Misses are dropped here and
// abort goes to every downstream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_req_route (
  input  logic                            clk,
  input  logic                            rst,
  csr_req_if.sink                         dec,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0] ds_req_valid,
  output logic [`CSR_NUM_DOWNSTREAMS-1:0] ds_req_abort,
  output csr_demux_pkg::csr_req_t         ds_req [`CSR_NUM_DOWNSTREAMS]
);

  localparam int N = `CSR_NUM_DOWNSTREAMS;
  localparam int S = `CSR_RETIME_STAGES;

  logic                       out_valid;
  logic                       out_abort;
  csr_demux_pkg::target_idx_t out_target;
  csr_demux_pkg::csr_req_t    out_req;

  if (S == 0) begin : gen_pass
    assign out_valid  = dec.valid && dec.hit;
    assign out_abort  = dec.abort;
    assign out_target = dec.target;
    assign out_req    = dec.req;
  end else begin : gen_retime
    logic                       valid_q  [S];
    logic                       abort_q  [S];
    csr_demux_pkg::target_idx_t target_q [S];
    csr_demux_pkg::csr_req_t    req_q    [S];

    // Only hits enter the pipe, so a miss never reaches a target
    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < S; i++) begin
          valid_q[i] <= 1'b0;
          abort_q[i] <= 1'b0;
        end
      end else begin
        valid_q[0] <= dec.valid && dec.hit;
        abort_q[0] <= dec.abort;
        for (int i = 1; i < S; i++) begin
          valid_q[i] <= valid_q[i-1];
          abort_q[i] <= abort_q[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      target_q[0] <= dec.target;
      req_q[0]    <= dec.req;
      for (int i = 1; i < S; i++) begin
        target_q[i] <= target_q[i-1];
        req_q[i]    <= req_q[i-1];
      end
    end

    assign out_valid  = valid_q[S-1];
    assign out_abort  = abort_q[S-1];
    assign out_target = target_q[S-1];
    assign out_req    = req_q[S-1];
  end

  // One-hot valid to the decoded target, shared payload for all
  always_comb begin
    for (int i = 0; i < N; i++) begin
      ds_req_valid[i] = out_valid && (out_target == csr_demux_pkg::target_idx_t'(i));
      ds_req_abort[i] = out_abort;
      ds_req[i]       = out_req;
    end
  end

endmodule

`default_nettype wire

// File: verilog/csr_req_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decode against static inclusive windows. Overlaps resolve
// to the lowest index and are not checked here
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

module csr_req_decode (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 req_valid,
  input  logic                                                 req_abort,
  input  csr_demux_pkg::csr_req_t                              req,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] addr_base,
  input  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_ADDR_WIDTH-1:0] addr_limit,
  csr_req_if.source                                            dec
);

  localparam int N = `CSR_NUM_DOWNSTREAMS;

  logic                       hit_d;
  csr_demux_pkg::target_idx_t target_d;

  // Walk downward so the lowest matching window wins
  always_comb begin
    hit_d    = 1'b0;
    target_d = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if ((req.addr >= addr_base[i]) && (req.addr <= addr_limit[i])) begin
        hit_d    = 1'b1;
        target_d = csr_demux_pkg::target_idx_t'(i);
      end
    end
  end

  // Control strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
      dec.abort <= 1'b0;
      dec.hit   <= 1'b0;
    end else begin
      dec.valid <= req_valid;
      dec.abort <= req_abort;
      dec.hit   <= hit_d;
    end
  end

  // Payload is qualified by dec.valid
  always_ff @(posedge clk) begin
    dec.target <= target_d;
    dec.req    <= req;
  end

endmodule

`default_nettype wire

// File: verilog/csr_demux_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal links of the CSR demux. Plain strobes without ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "csr_demux_defines.svh"

// Decoded request from the decode stage
interface csr_req_if;
  logic                      valid;
  logic                      abort;
  logic                      hit;
  csr_demux_pkg::target_idx_t target;
  csr_demux_pkg::csr_req_t    req;

  modport source (output valid, output abort, output hit, output target, output req);
  modport sink (input valid, input abort, input hit, input target, input req);

  // Response side only needs to spot misses
  modport monitor (input valid, input hit);
endinterface

// Per-downstream response strobes and payloads
interface csr_resp_if;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      valid;
  logic [`CSR_NUM_DOWNSTREAMS-1:0][`CSR_DATA_WIDTH-1:0] rdata;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      decerr;
  logic [`CSR_NUM_DOWNSTREAMS-1:0]                      slverr;

  modport sink (input valid, input rdata, input decerr, input slverr);
endinterface

`default_nettype wire

// File: verilog/csr_demux_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request, response and target index types shared by the CSR demux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "csr_demux_defines.svh"

package csr_demux_pkg;

  // Request payload as seen by every downstream
  typedef struct packed {
    logic                        write;
    logic                        privileged;
    logic                        secure;
    logic [`CSR_ADDR_WIDTH-1:0]  addr;
    logic [`CSR_DATA_WIDTH-1:0]  wdata;
    logic [`CSR_STRB_WIDTH-1:0]  wstrb;
  } csr_req_t;

  // Response payload returned upstream
  typedef struct packed {
    logic [`CSR_DATA_WIDTH-1:0] rdata;
    logic                       decerr;
    logic                       slverr;
  } csr_resp_t;

  typedef logic [$clog2(`CSR_NUM_DOWNSTREAMS)-1:0] target_idx_t;

endpackage

`default_nettype wire

// File: verilog/csr_demux_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR demux sizing. Strobe width must stay one bit per data byte and
// the retime depth may be 0, 1 or 2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CSR_DEMUX_DEFINES_SVH
`define CSR_DEMUX_DEFINES_SVH

// Bus widths
`define CSR_ADDR_WIDTH 16
`define CSR_DATA_WIDTH 32
`define CSR_STRB_WIDTH (`CSR_DATA_WIDTH / 8)

// Number of downstream targets behind the demux
`define CSR_NUM_DOWNSTREAMS 3

// Register stages between decode and the downstream ports
`define CSR_RETIME_STAGES 1

`endif
